//--- pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// data, instruction and register index widths
`define XLEN        64
`define ILEN        32
`define REG_ADDR_W  5
`define MASK_BITS   8

`define RESET_PC    64'h8000_0000

// major opcodes
`define OP_OP       7'b0110011
`define OP_IMM      7'b0010011
`define OP_32       7'b0111011
`define OP_IMM_32   7'b0011011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_SYSTEM   7'b1110011

// funct3 for the ALU groups
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 for the memory sizes
`define F3_W        3'b010
`define F3_D        3'b011

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`define INST_ECALL  32'h0000_0073

// byte strobes for a word and a doubleword access
`define MASK_WORD   8'h0f
`define MASK_DWORD  8'hff

`endif

//--- pipe_pkg.sv
`include "pipe_macros.svh"

package pipe_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`ILEN-1:0]       inst_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`MASK_BITS-1:0]  mask_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B     // LUI only, the U immediate goes straight through
    } alu_op_e;

    // ******************************************************************
    // decode to execute bundle
    // ******************************************************************
    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        alu_op_e   alu_op;
        logic      word;        // 32 bit form, result is sign extended from bit 31
        xlen_t     src1;
        xlen_t     src2;
        xlen_t     store_data;
        logic      mem_ena;
        logic      mem_wen;
        mask_t     mem_mask;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      sys;
        logic      illegal;
    } id_ex_t;

    // ******************************************************************
    // execute to memory bundle
    // ******************************************************************
    typedef struct packed {
        xlen_t     pc;
        xlen_t     alu_res;     // also the memory address for loads and stores
        xlen_t     store_data;
        logic      mem_ena;
        logic      mem_wen;
        mask_t     mem_mask;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      sys;
        logic      illegal;
    } ex_mem_t;

    localparam id_ex_t ID_EX_RESET = '{
        pc:         `RESET_PC,
        inst:       '0,
        alu_op:     ALU_ADD,
        word:       1'b0,
        src1:       '0,
        src2:       '0,
        store_data: '0,
        mem_ena:    1'b0,
        mem_wen:    1'b0,
        mem_mask:   '0,
        rf_we:      1'b0,
        rf_waddr:   '0,
        sys:        1'b0,
        illegal:    1'b0
    };

    localparam ex_mem_t EX_MEM_RESET = '{
        pc:         `RESET_PC,
        alu_res:    '0,
        store_data: '0,
        mem_ena:    1'b0,
        mem_wen:    1'b0,
        mem_mask:   '0,
        rf_we:      1'b0,
        rf_waddr:   '0,
        sys:        1'b0,
        illegal:    1'b0
    };

endpackage

//--- id_stage.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module id_stage
    import pipe_pkg::*;
(
    input  xlen_t  pc,
    input  inst_t  inst,
    input  xlen_t  rs1_data,
    input  xlen_t  rs2_data,
    output id_ex_t dec
);

    logic [6:0] opcode;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    logic       bad;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};

    // funct3 mapping shared by the register and immediate forms
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            `F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     op = ALU_SLL;
            `F3_SLT:     op = ALU_SLT;
            `F3_SLTU:    op = ALU_SLTU;
            `F3_XOR:     op = ALU_XOR;
            `F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec        = '0;
        dec.pc     = pc;
        dec.inst   = inst;
        dec.alu_op = ALU_ADD;
        dec.src1   = rs1_data;
        dec.src2   = rs2_data;
        dec.rf_we  = 1'b1;
        bad        = 1'b0;

        case (opcode)
            `OP_OP: begin
                dec.alu_op = f3_op(funct3, funct7[5]);
                if (funct7 == `F7_ALT)
                    bad = !(funct3 == `F3_ADD_SUB || funct3 == `F3_SRL_SRA);
                else
                    bad = (funct7 != `F7_BASE);
            end
            `OP_IMM: begin
                dec.src2   = imm_i;
                dec.alu_op = f3_op(funct3, 1'b0);
                bad        = (funct3 == `F3_SLL || funct3 == `F3_SRL_SRA); // no immediate shifts
            end
            `OP_32: begin
                dec.word   = 1'b1;
                dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                bad        = (funct3 != `F3_ADD_SUB) ||
                             (funct7 != `F7_BASE && funct7 != `F7_ALT);
            end
            `OP_IMM_32: begin
                dec.word = 1'b1;
                dec.src2 = imm_i;
                bad      = (funct3 != `F3_ADD_SUB);
            end
            `OP_LUI: begin
                dec.src1   = '0;
                dec.src2   = imm_u;
                dec.alu_op = ALU_PASS_B;
            end
            `OP_AUIPC: begin
                dec.src1 = pc;
                dec.src2 = imm_u;
            end
            `OP_LOAD: begin
                dec.src2     = imm_i;  // address is rs1 plus the I offset
                dec.mem_ena  = 1'b1;
                dec.mem_mask = (funct3 == `F3_D) ? `MASK_DWORD : `MASK_WORD;
                bad          = (funct3 != `F3_W && funct3 != `F3_D);
            end
            `OP_STORE: begin
                dec.src2       = imm_s;
                dec.store_data = rs2_data;
                dec.mem_ena    = 1'b1;
                dec.mem_wen    = 1'b1;
                dec.mem_mask   = (funct3 == `F3_D) ? `MASK_DWORD : `MASK_WORD;
                dec.rf_we      = 1'b0;
                bad            = (funct3 != `F3_W && funct3 != `F3_D);
            end
            `OP_SYSTEM: begin
                // only ECALL is recognised, every other system encoding traps
                dec.rf_we = 1'b0;
                dec.sys   = (inst == `INST_ECALL);
                bad       = (inst != `INST_ECALL);
            end
            default: bad = 1'b1;
        endcase

        if (bad) begin
            dec.illegal  = 1'b1;
            dec.rf_we    = 1'b0;
            dec.mem_ena  = 1'b0;
            dec.mem_wen  = 1'b0;
            dec.mem_mask = '0;
            dec.sys      = 1'b0;
        end

        dec.rf_waddr = dec.rf_we ? rd : '0;  // stores reuse these bits for the offset
    end

endmodule

//--- stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type T         = logic,
    parameter T    RESET_VAL = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic ena,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data  <= RESET_VAL;
        end else if (ena) begin
            out_valid <= in_valid;
            // a bubble passes through the valid bit only, the payload stays
            if (in_valid) begin
                out_data <= in_data;
            end
        end
    end

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module ex_stage
    import pipe_pkg::*;
(
    input  id_ex_t  ex,
    output ex_mem_t res
);

    xlen_t      a;        // first operand as the shifter sees it
    xlen_t      b;
    logic [5:0] shamt;
    xlen_t      raw;
    xlen_t      alu_res;

    // ******************************************************************
    // operand preparation
    // ******************************************************************
    always_comb begin
        a = ex.src1;
        if (ex.word) begin
            // word shifts only see the low half of rs1
            if (ex.alu_op == ALU_SRA)
                a = {{(`XLEN-32){ex.src1[31]}}, ex.src1[31:0]};
            else
                a = {{(`XLEN-32){1'b0}}, ex.src1[31:0]};
        end
    end

    assign b     = ex.src2;
    assign shamt = ex.word ? {1'b0, b[4:0]} : b[5:0];

    // ******************************************************************
    // ALU
    // ******************************************************************
    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    raw = a + b;       // also the load and store address
            ALU_SUB:    raw = a - b;
            ALU_AND:    raw = a & b;
            ALU_OR:     raw = a | b;
            ALU_XOR:    raw = a ^ b;
            ALU_SLL:    raw = a << shamt;
            ALU_SRL:    raw = a >> shamt;
            ALU_SRA:    raw = xlen_t'($signed(a) >>> shamt);
            ALU_SLT:    raw = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   raw = {{(`XLEN-1){1'b0}}, a < b};
            ALU_PASS_B: raw = b;
            default:    raw = '0;
        endcase
    end

    assign alu_res = ex.word ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

    always_comb begin
        res.pc         = ex.pc;
        res.alu_res    = alu_res;
        res.store_data = ex.store_data;
        res.mem_ena    = ex.mem_ena;
        res.mem_wen    = ex.mem_wen;
        res.mem_mask   = ex.mem_mask;
        res.rf_we      = ex.rf_we;
        res.rf_waddr   = ex.rf_waddr;
        res.sys        = ex.sys;
        res.illegal    = ex.illegal;
    end

endmodule

//--- ex_pipe_top.sv
`timescale 1ns/1ps

module ex_pipe_top
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    in_valid,
    output logic    in_ready,
    input  xlen_t   in_pc,
    input  inst_t   in_inst,
    input  xlen_t   in_rs1_data,
    input  xlen_t   in_rs2_data,

    output logic    out_valid,
    input  logic    out_ready,
    output ex_mem_t out
);

    logic    advance;
    id_ex_t  id_bundle;
    logic    ex_valid;
    id_ex_t  ex_bundle;
    ex_mem_t ex_result;

    // the whole pipe moves or the whole pipe holds
    assign advance  = out_ready || !out_valid;
    assign in_ready = advance;

    id_stage id_stage0 (
        .pc       (in_pc),
        .inst     (in_inst),
        .rs1_data (in_rs1_data),
        .rs2_data (in_rs2_data),
        .dec      (id_bundle)
    );

    stage_reg #(.T(id_ex_t), .RESET_VAL(ID_EX_RESET)) id_ex_reg (
        .clk       (clk),
        .rst       (rst),
        .ena       (advance),
        .in_valid  (in_valid),
        .in_data   (id_bundle),
        .out_valid (ex_valid),
        .out_data  (ex_bundle)
    );

    ex_stage ex_stage0 (
        .ex  (ex_bundle),
        .res (ex_result)
    );

    stage_reg #(.T(ex_mem_t), .RESET_VAL(EX_MEM_RESET)) ex_mem_reg (
        .clk       (clk),
        .rst       (rst),
        .ena       (advance),
        .in_valid  (ex_valid),
        .in_data   (ex_result),
        .out_valid (out_valid),
        .out_data  (out)
    );

endmodule

//--- ex_pipe_sva.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module ex_pipe_sva
    import pipe_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    in_valid,
    input logic    in_ready,
    input logic    ex_valid,
    input logic    out_valid,
    input logic    out_ready,
    input ex_mem_t out
);

    // ******************************************************************
    // valid/ready protocol
    // ******************************************************************
    // in_ready is the advance that both stage registers take
    a_ready_moves: assert property (@(posedge clk) disable iff (rst)
        in_ready |=> (ex_valid == $past(in_valid) && out_valid == $past(ex_valid)))
        else $error("pipe did not advance while in_ready was high");

    a_ready_holds: assert property (@(posedge clk) disable iff (rst)
        !in_ready |=> ($stable(ex_valid) && $stable(out_valid)))
        else $error("pipe moved while in_ready was low");

    // a stalled result must not move or change
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out)))
        else $error("out changed while stalled");

    // ******************************************************************
    // reset state
    // ******************************************************************
    a_reset_valid: assert property (@(posedge clk)
        rst |=> (!out_valid && !ex_valid))
        else $error("valid bits not cleared by reset");

    a_reset_pc: assert property (@(posedge clk)
        rst |=> (out.pc == `RESET_PC))
        else $error("out.pc not at reset pc after reset");

    a_reset_payload: assert property (@(posedge clk)
        rst |=> (out.alu_res == '0 && !out.rf_we && !out.mem_ena))
        else $error("out payload not cleared by reset");

endmodule

bind ex_pipe_top ex_pipe_sva sva0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .ex_valid  (ex_valid),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out)
);

//--- tb_ex_pipe.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module tb_ex_pipe
    import pipe_pkg::*;
();

    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 2000;         // cycles allowed for any single wait loop

    logic    clk;
    logic    rst;
    logic    in_valid;
    logic    in_ready;
    xlen_t   in_pc;
    inst_t   in_inst;
    xlen_t   in_rs1_data;
    xlen_t   in_rs2_data;
    logic    out_valid;
    logic    out_ready;
    ex_mem_t out;

    xlen_t   c_pc [MAX_CASES];
    inst_t   c_inst [MAX_CASES];
    xlen_t   c_rs1 [MAX_CASES];
    xlen_t   c_rs2 [MAX_CASES];
    ex_mem_t c_exp [MAX_CASES];
    int      n_cases;

    int pend_idx[$];                         // case index of every instruction in flight
    int pend_cycle[$];
    int cycle;
    int n_accepted;
    int n_done;
    int cur;
    bit strict;
    int pop_idx;
    int pop_cycle;
    int value_errs;
    int proto_errs;
    int timeouts;

    ex_pipe_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL time %0t %s expected %b actual %b", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_res(input int idx, input ex_mem_t exp, input ex_mem_t act);
        string tag;
        tag = $sformatf("[case %0d]", idx);
        check_xlen({"out.pc", tag}, exp.pc, act.pc);
        check_xlen({"out.alu_res", tag}, exp.alu_res, act.alu_res);
        check_xlen({"out.store_data", tag}, exp.store_data, act.store_data);
        check_xlen({"out.mem_mask", tag}, xlen_t'(exp.mem_mask), xlen_t'(act.mem_mask));
        check_xlen({"out.rf_waddr", tag}, xlen_t'(exp.rf_waddr), xlen_t'(act.rf_waddr));
        check_bit({"out.mem_ena", tag}, exp.mem_ena, act.mem_ena);
        check_bit({"out.mem_wen", tag}, exp.mem_wen, act.mem_wen);
        check_bit({"out.rf_we", tag}, exp.rf_we, act.rf_we);
        check_bit({"out.sys", tag}, exp.sys, act.sys);
        check_bit({"out.illegal", tag}, exp.illegal, act.illegal);
    endtask

    // ******************************************************************
    // case file loader
    // ******************************************************************
    task automatic load_cases();
        int      fd;
        int      r;
        string   line;
        xlen_t   pc, rs1, rs2, res;
        inst_t   inst;
        int      we, waddr, mena, mwen, mask, sys, ill;
        ex_mem_t e;
        n_cases = 0;
        fd = $fopen("ex_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file ex_cases.txt");
            proto_errs++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            r = $fgets(line, fd);
            if (r == 0 || line.len() < 8 || line[0] == "#")
                continue;
            r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        pc, inst, rs1, rs2, res, we, waddr, mena, mwen, mask, sys, ill);
            if (r != 12) begin
                $display("malformed line in the cases file: %s", line);
                proto_errs++;
                continue;
            end
            e            = '0;
            e.pc         = pc;
            e.alu_res    = res;
            e.store_data = (mwen != 0) ? rs2 : '0;   // stores carry rs2 to memory
            e.mem_ena    = (mena != 0);
            e.mem_wen    = (mwen != 0);
            e.mem_mask   = mask_t'(mask);
            e.rf_we      = (we != 0);
            e.rf_waddr   = reg_addr_t'(waddr);
            e.sys        = (sys != 0);
            e.illegal    = (ill != 0);
            c_pc[n_cases]   = pc;
            c_inst[n_cases] = inst;
            c_rs1[n_cases]  = rs1;
            c_rs2[n_cases]  = rs2;
            c_exp[n_cases]  = e;
            n_cases++;
        end
        $fclose(fd);
    endtask

    // ******************************************************************
    // transfer monitor that sees the pre-edge values on both sides
    // ******************************************************************
    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                if (pend_idx.size() == 0) begin
                    $display("time %0t: a result came out with nothing in flight", $time);
                    proto_errs++;
                end else begin
                    pop_idx   = pend_idx.pop_front();
                    pop_cycle = pend_cycle.pop_front();
                    check_res(pop_idx, c_exp[pop_idx], out);
                    if (strict && (cycle - pop_cycle) != 2) begin
                        $display("FAIL time %0t latency[case %0d] expected 2 actual %0d",
                                 $time, pop_idx, cycle - pop_cycle);
                        value_errs++;
                    end
                    n_done++;
                end
            end
            if (in_valid && in_ready) begin
                pend_idx.push_back(cur);
                pend_cycle.push_back(cycle);
                n_accepted++;
            end
        end
        cycle++;
    end

    task automatic drive_cases(input bit hold_steady);
        int guard;
        int first;
        int done_first;
        strict     = hold_steady;
        first      = n_accepted;
        done_first = n_done;
        guard      = 0;
        while ((n_accepted - first) < n_cases && guard < TIMEOUT) begin
            @(negedge clk);
            cur = n_accepted - first;
            if (cur < n_cases) begin
                in_valid    = hold_steady ? 1'b1 : ($urandom % 4 != 0);
                in_pc       = c_pc[cur];
                in_inst     = c_inst[cur];
                in_rs1_data = c_rs1[cur];
                in_rs2_data = c_rs2[cur];
            end else begin
                in_valid = 1'b0;
            end
            out_ready = hold_steady ? 1'b1 : ($urandom % 3 != 0);
            guard++;
        end
        if (guard >= TIMEOUT) begin
            $display("timed out waiting for the DUT to accept all instructions");
            timeouts++;
        end
        in_valid = 1'b0;
        guard    = 0;
        while ((n_done - done_first) < n_cases && guard < TIMEOUT) begin
            @(negedge clk);
            in_valid  = 1'b0;
            out_ready = hold_steady ? 1'b1 : ($urandom % 3 != 0);
            guard++;
        end
        if (guard >= TIMEOUT) begin
            $display("timed out waiting for the pipeline to drain");
            timeouts++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_pc       = '0;
        in_inst     = '0;
        in_rs1_data = '0;
        in_rs2_data = '0;
        out_ready   = 1'b0;
        strict      = 1'b0;
        cur         = 0;
        cycle       = 0;
        n_accepted  = 0;
        n_done      = 0;
        value_errs  = 0;
        proto_errs  = 0;
        timeouts    = 0;
        void'($urandom(32'he1e2_bd01));

        load_cases();
        if (n_cases == 0) begin
            $display("no instructions were loaded from the cases file");
            proto_errs++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit("out_valid", 1'b0, out_valid);   // idle pipe right after reset
        check_bit("in_ready", 1'b1, in_ready);

        drive_cases(1'b0);                          // random gaps and stalls
        drive_cases(1'b1);                          // back to back with fixed latency

        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errs, proto_errs, timeouts);
        if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- ex_cases.txt
# pc inst rs1 rs2 alu_res rf_we rf_waddr mem_ena mem_wen mem_mask sys illegal
# all columns in hex, one instruction per line
80000000 002081b3 ffffffffffffff00 4 ffffffffffffff04 1 3 0 0 00 0 0
80000004 402081b3 ffffffffffffff00 4 fffffffffffffefc 1 3 0 0 00 0 0
80000008 002091b3 ffffffffffffff00 4 fffffffffffff000 1 3 0 0 00 0 0
8000000c 0020a1b3 ffffffffffffff00 4 1 1 3 0 0 00 0 0
80000010 0020b1b3 ffffffffffffff00 4 0 1 3 0 0 00 0 0
80000014 0020d1b3 ffffffffffffff00 4 0ffffffffffffff0 1 3 0 0 00 0 0
80000018 4020d1b3 ffffffffffffff00 4 fffffffffffffff0 1 3 0 0 00 0 0
8000001c 0020c1b3 f0f0f0f0 ff00ff00 0ff00ff0 1 3 0 0 00 0 0
80000020 0020e1b3 f0f0f0f0 ff00ff00 fff0fff0 1 3 0 0 00 0 0
80000024 0020f1b3 f0f0f0f0 ff00ff00 f000f000 1 3 0 0 00 0 0
80000028 fff08293 10 0 f 1 5 0 0 00 0 0
8000002c 0f00f293 1234 0 30 1 5 0 0 00 0 0
80000030 00f0e293 1230 0 123f 1 5 0 0 00 0 0
80000034 fff0c293 ff 0 ffffffffffffff00 1 5 0 0 00 0 0
80000038 0050a293 ffffffffffffffff 0 1 1 5 0 0 00 0 0
8000003c 0050b293 ffffffffffffffff 0 0 1 5 0 0 00 0 0
80000040 00001397 0 0 80001040 1 7 0 0 00 0 0
80000044 12345337 0 0 12345000 1 6 0 0 00 0 0
80000048 80000337 0 0 ffffffff80000000 1 6 0 0 00 0 0
8000004c 0020843b 7fffffff 1 ffffffff80000000 1 8 0 0 00 0 0
80000050 4020843b 0 1 ffffffffffffffff 1 8 0 0 00 0 0
80000054 0010841b 1ffffffff 0 0 1 8 0 0 00 0 0
80000058 0080b483 1000 0 1008 1 9 1 0 ff 0 0
8000005c ffc0a483 1000 0 ffc 1 9 1 0 0f 0 0
80000060 0020b823 2000 55aa 2010 0 0 1 1 ff 0 0
80000064 fe20ac23 2000 1234 1ff8 0 0 1 1 0f 0 0
80000068 00000073 0 0 0 0 0 0 0 00 1 0
8000006c ffffffff 0 0 0 0 0 0 0 00 0 1
80000070 00109293 0 0 0 0 0 0 0 00 0 1

//--- tb.f
+incdir+.
pipe_pkg.sv
id_stage.sv
stage_reg.sv
ex_stage.sv
ex_pipe_top.sv
ex_pipe_sva.sv
tb_ex_pipe.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ex_pipe
FILELIST = tb.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
